// File: src/cordic_sincos_pkg.sv
package cordic_sincos_pkg;

  ////////////////////
  // widths and depth
  ////////////////////

  localparam int data_width = 28; // phase word, x, y, z
  localparam int out_width  = 14;
  localparam int num_stages = 26;

  // fold (2) + rotations (26) + output register (1)
  localparam int latency = 29;

  ////////////////////
  // constants
  ////////////////////

  // full word is one turn
  localparam logic [data_width-1:0] quarter_turn = 28'd67108864;

  // 0.60725 * 2^27, pre-scaled so the rotator gain cancels
  localparam logic [data_width-1:0] cordic_gain = 28'd81503715;

  localparam logic [out_width-1:0] out_offset = 14'd8192; // midscale

  // atan(2^-i) in phase units, entry 0 is 45 deg
  localparam logic [0:num_stages-1][data_width-1:0] atan_table = {
    28'd33554432,
    28'd19808338,
    28'd10466181,
    28'd5312797,
    28'd2666708,
    28'd1334654,
    28'd667489,
    28'd333765,
    28'd166885,
    28'd83442,
    28'd41721,
    28'd20860,
    28'd10430,
    28'd5215,
    28'd2607,
    28'd1303,
    28'd651,
    28'd325,
    28'd162,
    28'd81,
    28'd40,
    28'd20,
    28'd10,
    28'd5,
    28'd2,
    28'd1
  };

  ////////////////////
  // quadrant code
  ////////////////////

  // top two phase bits
  typedef enum logic [1:0] {
    quad_first,
    quad_second,
    quad_third,
    quad_fourth
  } quad_e;

endpackage

// File: src/quadrant_fold.sv
module quadrant_fold (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [cordic_sincos_pkg::data_width-1:0] phase,
  input  logic                                    phase_valid,
  output logic [cordic_sincos_pkg::data_width-1:0] x_start,
  output logic [cordic_sincos_pkg::data_width-1:0] y_start,
  output logic [cordic_sincos_pkg::data_width-1:0] z_start,
  output logic                                    start_valid,
  output cordic_sincos_pkg::quad_e                quadrant,
  output logic                                    quadrant_valid
);

  cordic_sincos_pkg::quad_e                quad_in;
  logic [cordic_sincos_pkg::data_width-1:0] folded;
  logic [cordic_sincos_pkg::data_width-1:0] folded_r;

  // residual lands in [0, quarter_turn)
  always_comb
  begin
    quad_in = cordic_sincos_pkg::quad_e'(phase[cordic_sincos_pkg::data_width-1 -: 2]);
    folded  = phase - cordic_sincos_pkg::quarter_turn
                    * cordic_sincos_pkg::data_width'(quad_in);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      folded_r       <= '0;
      quadrant       <= cordic_sincos_pkg::quad_first;
      quadrant_valid <= 1'b0;
    end
    else
    begin
      folded_r       <= folded;
      quadrant       <= quad_in;
      quadrant_valid <= phase_valid;
    end
  end

  // starting vector (gain, 0) at the folded angle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_start     <= '0;
      y_start     <= '0;
      z_start     <= '0;
      start_valid <= 1'b0;
    end
    else
    begin
      x_start     <= cordic_sincos_pkg::cordic_gain;
      y_start     <= '0;
      z_start     <= folded_r;
      start_valid <= quadrant_valid;
    end
  end

endmodule

// File: src/cordic_stage.sv
module cordic_stage #(
  parameter int                                     shift = 0,
  parameter logic [cordic_sincos_pkg::data_width-1:0] angle = '0
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [cordic_sincos_pkg::data_width-1:0] x_in,
  input  logic [cordic_sincos_pkg::data_width-1:0] y_in,
  input  logic [cordic_sincos_pkg::data_width-1:0] z_in,
  input  logic                                    valid_in,
  output logic [cordic_sincos_pkg::data_width-1:0] x_out,
  output logic [cordic_sincos_pkg::data_width-1:0] y_out,
  output logic [cordic_sincos_pkg::data_width-1:0] z_out,
  output logic                                    valid_out
);

  logic signed [cordic_sincos_pkg::data_width-1:0] x_shift;
  logic signed [cordic_sincos_pkg::data_width-1:0] y_shift;

  // sign-extending shift
  assign x_shift = $signed(x_in) >>> shift;
  assign y_shift = $signed(y_in) >>> shift;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_out     <= '0;
      y_out     <= '0;
      z_out     <= '0;
      valid_out <= 1'b0;
    end
    else
    begin
      valid_out <= valid_in;
      if (!z_in[cordic_sincos_pkg::data_width-1]) // angle left, turn ccw
      begin
        x_out <= x_in - y_shift;
        y_out <= y_in + x_shift;
        z_out <= z_in - angle;
      end
      else
      begin
        x_out <= x_in + y_shift;
        y_out <= y_in - x_shift;
        z_out <= z_in + angle;
      end
    end
  end

endmodule

// File: src/cordic_rotator.sv
module cordic_rotator (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [cordic_sincos_pkg::data_width-1:0] x_in,
  input  logic [cordic_sincos_pkg::data_width-1:0] y_in,
  input  logic [cordic_sincos_pkg::data_width-1:0] z_in,
  input  logic                                    valid_in,
  output logic [cordic_sincos_pkg::data_width-1:0] x_out,
  output logic [cordic_sincos_pkg::data_width-1:0] y_out,
  output logic                                    valid_out
);

  // entry 0 is the input, entry i+1 the output of stage i
  logic [cordic_sincos_pkg::data_width-1:0] x_chain [0:cordic_sincos_pkg::num_stages];
  logic [cordic_sincos_pkg::data_width-1:0] y_chain [0:cordic_sincos_pkg::num_stages];
  logic [cordic_sincos_pkg::data_width-1:0] z_chain [0:cordic_sincos_pkg::num_stages];
  logic                                     v_chain [0:cordic_sincos_pkg::num_stages];

  assign x_chain[0] = x_in;
  assign y_chain[0] = y_in;
  assign z_chain[0] = z_in;
  assign v_chain[0] = valid_in;

  for (genvar i = 0; i < cordic_sincos_pkg::num_stages; i++)
  begin : g_stage
    cordic_stage #(
      .shift (i),
      .angle (cordic_sincos_pkg::atan_table[i])
    ) u_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .x_in      (x_chain[i]),
      .y_in      (y_chain[i]),
      .z_in      (z_chain[i]),
      .valid_in  (v_chain[i]),
      .x_out     (x_chain[i+1]),
      .y_out     (y_chain[i+1]),
      .z_out     (z_chain[i+1]),
      .valid_out (v_chain[i+1])
    );
  end

  // residual angle of the last stage is left unused
  assign x_out     = x_chain[cordic_sincos_pkg::num_stages];
  assign y_out     = y_chain[cordic_sincos_pkg::num_stages];
  assign valid_out = v_chain[cordic_sincos_pkg::num_stages];

endmodule

// File: src/quadrant_unfold.sv
module quadrant_unfold (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  cordic_sincos_pkg::quad_e                quadrant,
  input  logic                                    quadrant_valid,
  input  logic [cordic_sincos_pkg::data_width-1:0] x_in,
  input  logic [cordic_sincos_pkg::data_width-1:0] y_in,
  input  logic                                    rot_valid,
  output logic [cordic_sincos_pkg::out_width-1:0]  sin,
  output logic [cordic_sincos_pkg::out_width-1:0]  cos,
  output logic                                    out_valid
);

  // 27 entries, one per rotator stage plus the vector load
  cordic_sincos_pkg::quad_e quad_pipe  [0:cordic_sincos_pkg::num_stages];
  logic                     valid_pipe [0:cordic_sincos_pkg::num_stages];

  cordic_sincos_pkg::quad_e                quad_dly;
  logic                                    quadrant_valid_dly; // must track rot_valid
  logic [cordic_sincos_pkg::data_width-1:0] sin_r;
  logic [cordic_sincos_pkg::data_width-1:0] cos_r;

  ////////////////////
  // quadrant delay
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i <= cordic_sincos_pkg::num_stages; i++)
      begin
        quad_pipe[i]  <= cordic_sincos_pkg::quad_first;
        valid_pipe[i] <= 1'b0;
      end
    end
    else
    begin
      quad_pipe[0]  <= quadrant;
      valid_pipe[0] <= quadrant_valid;
      for (int i = 1; i <= cordic_sincos_pkg::num_stages; i++)
      begin
        quad_pipe[i]  <= quad_pipe[i-1];
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  assign quad_dly           = quad_pipe[cordic_sincos_pkg::num_stages];
  assign quadrant_valid_dly = valid_pipe[cordic_sincos_pkg::num_stages];

  ////////////////////
  // restore
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sin_r     <= '0;
      cos_r     <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= rot_valid;
      case (quad_dly)
        cordic_sincos_pkg::quad_first:
        begin
          sin_r <= y_in;
          cos_r <= x_in;
        end
        cordic_sincos_pkg::quad_second: // +90 deg
        begin
          sin_r <= x_in;
          cos_r <= -y_in;
        end
        cordic_sincos_pkg::quad_third:
        begin
          sin_r <= -y_in;
          cos_r <= -x_in;
        end
        default:
        begin
          sin_r <= -x_in;
          cos_r <= y_in;
        end
      endcase
    end
  end

  // top bits to offset binary, wraps mod 2^14
  assign sin = sin_r[cordic_sincos_pkg::data_width-1 -: cordic_sincos_pkg::out_width]
             + cordic_sincos_pkg::out_offset;
  assign cos = cos_r[cordic_sincos_pkg::data_width-1 -: cordic_sincos_pkg::out_width]
             + cordic_sincos_pkg::out_offset;

endmodule

// File: src/cordic_sincos.sv
module cordic_sincos (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [cordic_sincos_pkg::data_width-1:0] phase,
  input  logic                                    phase_valid,
  output logic [cordic_sincos_pkg::out_width-1:0]  sin,
  output logic [cordic_sincos_pkg::out_width-1:0]  cos,
  output logic                                    out_valid
);

  logic [cordic_sincos_pkg::data_width-1:0] x_start;
  logic [cordic_sincos_pkg::data_width-1:0] y_start;
  logic [cordic_sincos_pkg::data_width-1:0] z_start;
  logic                                     start_valid;

  cordic_sincos_pkg::quad_e quadrant;
  logic                     quadrant_valid;

  logic [cordic_sincos_pkg::data_width-1:0] x_rot;
  logic [cordic_sincos_pkg::data_width-1:0] y_rot;
  logic                                     rot_valid;

  quadrant_fold u_fold (
    .clk            (clk),
    .rst_n          (rst_n),
    .phase          (phase),
    .phase_valid    (phase_valid),
    .x_start        (x_start),
    .y_start        (y_start),
    .z_start        (z_start),
    .start_valid    (start_valid),
    .quadrant       (quadrant),
    .quadrant_valid (quadrant_valid)
  );

  cordic_rotator u_rotator (
    .clk       (clk),
    .rst_n     (rst_n),
    .x_in      (x_start),
    .y_in      (y_start),
    .z_in      (z_start),
    .valid_in  (start_valid),
    .x_out     (x_rot),
    .y_out     (y_rot),
    .valid_out (rot_valid)
  );

  // quadrant bypasses the rotator through its own delay line
  quadrant_unfold u_unfold (
    .clk            (clk),
    .rst_n          (rst_n),
    .quadrant       (quadrant),
    .quadrant_valid (quadrant_valid),
    .x_in           (x_rot),
    .y_in           (y_rot),
    .rot_valid      (rot_valid),
    .sin            (sin),
    .cos            (cos),
    .out_valid      (out_valid)
  );

endmodule

// File: bench/cordic_sincos_props.sv
module cordic_sincos_props (
  input logic clk,
  input logic rst_n,
  input logic phase_valid,
  input logic out_valid,
  input logic rot_valid,
  input logic quad_valid_dly
);

  int fail_count = 0; // read by the testbench summary

  assert property (@(posedge clk) !rst_n |-> !out_valid)
  else
  begin
    fail_count++;
    $error("out_valid high while in reset");
  end

  // valid strobe rides the whole pipeline
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(phase_valid, cordic_sincos_pkg::latency))
  else
  begin
    fail_count++;
    $error("out_valid does not match phase_valid from %0d cycles back",
           cordic_sincos_pkg::latency);
  end

  assert property (@(posedge clk) disable iff (!rst_n) quad_valid_dly == rot_valid)
  else
  begin
    fail_count++;
    $error("quadrant delay line out of step with the rotator");
  end

endmodule

bind cordic_sincos cordic_sincos_props props_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .phase_valid    (phase_valid),
  .out_valid      (out_valid),
  .rot_valid      (rot_valid),
  .quad_valid_dly (u_unfold.quadrant_valid_dly)
);

// File: bench/cordic_sincos_tb.sv
module cordic_sincos_tb;

  localparam int dw          = cordic_sincos_pkg::data_width;
  localparam int ow          = cordic_sincos_pkg::out_width;
  localparam int lat         = cordic_sincos_pkg::latency;
  localparam int per_quad    = 50;
  localparam int max_gap     = 3;
  localparam int lat_phases  = 8;
  localparam int stream_len  = 200;
  localparam int sym_pairs   = 50;
  localparam int test_cycles = 10 + 4 * per_quad * (max_gap + 1) + lat_phases * (lat + 4)
                             + stream_len + sym_pairs * (max_gap + 2) + 4 * (lat + 10);

  logic          clk;
  logic          rst_n;
  logic [dw-1:0] phase;
  logic          phase_valid;
  logic [ow-1:0] sin;
  logic [ow-1:0] cos;
  logic          out_valid;

  integer seed   = 71353;
  int     cycle  = 0;
  int     checks = 0;
  int     errors = 0;

  logic [2*ow-1:0] exp_q [$]; // {sin, cos}
  int              stamp_q [$];
  logic [ow-1:0]   got_sin [$];
  logic [ow-1:0]   got_cos [$];
  int              got_cycle [$];
  logic [2*ow-1:0] pair;

  cordic_sincos dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .phase_valid (phase_valid),
    .sin         (sin),
    .cos         (cos),
    .out_valid   (out_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial
  begin
    #(longint'(test_cycles + lat + 50) * 100);
    $display("watchdog expired with %0d results still outstanding", exp_q.size());
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [2*ow-1:0] model_sincos(input logic [dw-1:0] p);
    logic signed [dw-1:0] x;
    logic signed [dw-1:0] y;
    logic signed [dw-1:0] z;
    logic signed [dw-1:0] xs;
    logic signed [dw-1:0] ys;
    logic signed [dw-1:0] s_full;
    logic signed [dw-1:0] c_full;
    int                   i;
    z = {2'b00, p[dw-3:0]}; // residual inside the quadrant
    x = cordic_sincos_pkg::cordic_gain;
    y = '0;
    for (i = 0; i < cordic_sincos_pkg::num_stages; i++)
    begin
      xs = x >>> i;
      ys = y >>> i;
      if (z >= 0)
      begin
        x = x - ys;
        y = y + xs;
        z = z - cordic_sincos_pkg::atan_table[i];
      end
      else
      begin
        x = x + ys;
        y = y - xs;
        z = z + cordic_sincos_pkg::atan_table[i];
      end
    end
    case (p[dw-1 -: 2])
      2'd0:
      begin
        s_full = y;
        c_full = x;
      end
      2'd1:
      begin
        s_full = x;
        c_full = -y;
      end
      2'd2:
      begin
        s_full = -y;
        c_full = -x;
      end
      default:
      begin
        s_full = -x;
        c_full = y;
      end
    endcase
    return {s_full[dw-1 -: ow] + ow'(8192), c_full[dw-1 -: ow] + ow'(8192)};
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  // equal within one lsb, mod 2^14
  task automatic check_close(input string name, input logic [ow-1:0] expected,
                             input logic [ow-1:0] actual);
    logic [ow-1:0] d;
    d = actual - expected;
    checks++;
    if (d != '0 && d != ow'(1) && d != '1)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_idle();
    check_value("out_valid", 0, out_valid);
    check_value("sin", cordic_sincos_pkg::out_offset, sin);
    check_value("cos", cordic_sincos_pkg::out_offset, cos);
  endtask

  task automatic drive_phase(input logic [dw-1:0] p);
    @(posedge clk);
    phase       <= p;
    phase_valid <= 1'b1;
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      phase_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < lat + 10)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0t %0d results never came out of the pipeline", $time, exp_q.size());
      exp_q.delete();
      stamp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("test %s finished with %0d errors", name, errors - start_errors);
  endtask

  ////////////////////
  // output monitor
  ////////////////////

  always @(negedge clk)
  begin
    if (phase_valid)
    begin
      exp_q.push_back(model_sincos(phase));
      stamp_q.push_back(cycle);
    end
    if (out_valid)
    begin
      got_sin.push_back(sin);
      got_cos.push_back(cos);
      got_cycle.push_back(cycle);
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("%0t out_valid pulse with no phase in flight", $time);
      end
      else
      begin
        pair = exp_q.pop_front();
        check_value("out_valid latency", lat, cycle - stamp_q.pop_front());
        check_value("sin", pair[2*ow-1:ow], sin);
        check_value("cos", pair[ow-1:0], cos);
      end
    end
  end

  initial
  begin
    int            e0;
    int            base;
    int            n;
    logic [dw-1:0] p;
    logic [ow-1:0] mirror;
    rst_n       = 1'b0;
    phase       = '0;
    phase_valid = 1'b0;

    e0 = errors;
    repeat (8)
    begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_idle();
    end
    report_test("reset_state", e0);

    e0 = errors;
    for (int q = 0; q < 4; q++)
    begin
      for (int k = 0; k < per_quad; k++)
      begin
        p              = dw'($random(seed));
        p[dw-1 -: 2]   = q[1:0]; // force the quadrant
        drive_phase(p);
        drive_idle(1 + int'({$random(seed)} % max_gap));
      end
    end
    wait_drain();
    report_test("random_quadrants", e0);

    e0 = errors;
    repeat (lat_phases)
    begin
      drive_phase(dw'($random(seed)));
      drive_idle(1);
      n = 0;
      do
      begin
        @(negedge clk);
        n++;
      end
      while (!out_valid && n < lat + 10);
      check_value("out_valid delay", lat, n);
      drive_idle(2);
    end
    wait_drain();
    report_test("fixed_latency", e0);

    e0   = errors;
    base = got_cycle.size();
    repeat (stream_len) drive_phase(dw'($random(seed)));
    drive_idle(1);
    wait_drain();
    check_value("out_valid pulses", stream_len, got_cycle.size() - base);
    for (int k = 1; k < stream_len && base + k < got_cycle.size(); k++)
    begin
      check_value("out_valid spacing", 1, got_cycle[base+k] - got_cycle[base+k-1]);
    end
    report_test("streaming", e0);

    e0   = errors;
    base = got_sin.size();
    repeat (sym_pairs)
    begin
      p = dw'($random(seed));
      drive_phase(p);
      drive_phase(p + cordic_sincos_pkg::quarter_turn); // wraps past a full turn
      drive_idle(1 + int'({$random(seed)} % max_gap));
    end
    wait_drain();
    if (got_sin.size() < base + 2 * sym_pairs)
    begin
      errors++;
      $display("%0t symmetry pairs incomplete", $time);
    end
    else
    begin
      for (int k = 0; k < sym_pairs; k++)
      begin
        mirror = ow'(0) - got_sin[base+2*k]; // 16384 - sin
        check_close("sin", got_cos[base+2*k], got_sin[base+2*k+1]);
        check_close("cos", mirror, got_cos[base+2*k+1]);
      end
    end
    report_test("quadrant_symmetry", e0);

    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut_i.props_i.fail_count);
    if (errors == 0 && dut_i.props_i.fail_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: cordic_sincos.f
src/cordic_sincos_pkg.sv
src/quadrant_fold.sv
src/cordic_stage.sv
src/cordic_rotator.sv
src/quadrant_unfold.sv
src/cordic_sincos.sv
bench/cordic_sincos_props.sv
bench/cordic_sincos_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module cordic_sincos_tb \
  -f cordic_sincos.f \
  -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "All tests passed!" sim.log \
  && echo "run_sim: PASS" \
  && exit 0 \
  || { echo "run_sim: FAIL"; exit 1; }
